// File: Makefile
# Verilator build and run of the display core testbench
# the run fails with the simulator's exit status

SRCS := $(filter %.sv,$(shell cat verilog.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_display_core: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_display_core -f verilog.f

run: obj_dir/Vtb_display_core
	./obj_dir/Vtb_display_core

clean:
	rm -rf obj_dir

// File: bridge_regs.sv
////////////////////////////////////////////////////////////
// bridge bus decode for the display core
// pixel writes go straight to frame memory, two control
// registers hold the border switch and display enable
////////////////////////////////////////////////////////////

module bridge_regs import display_pkg::*; (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  logic [31:0] bridge_addr,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,
    output fb_wr_t      fb_wr,
    output logic        border,
    output logic        display_enable
);

    logic mem_sel;

    // frame memory sits at the bottom 64 MB
    assign mem_sel = (bridge_addr[31:26] == 6'd0);

    // byte address to word address, written this same cycle
    always_comb begin
        fb_wr.wr       = bridge_wr && mem_sel;
        fb_wr.addr     = bridge_addr[25:2];
        fb_wr.data.raw = bridge_wr_data;
    end

    ////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////

    // border on and scanout off out of reset
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            border         <= 1'b1;
            display_enable <= 1'b0;
        end else if (bridge_wr) begin
            if (bridge_addr == addr_border) begin
                border <= bridge_wr_data[0];
            end
            if (bridge_addr == addr_enable) begin
                display_enable <= bridge_wr_data[0];
            end
        end
    end

    // read mux
    // only the border bit is visible, everything else is zero
    always_comb begin
        bridge_rd_data = 32'd0;
        if (bridge_rd && (bridge_addr == addr_border)) begin
            bridge_rd_data = {31'd0, border};
        end
    end

endmodule

// File: display_asserts.sv
////////////////////////////////////////////////////////////
// concurrent checks on the video outputs of the display core
// bound into display_core, fails through $error only
////////////////////////////////////////////////////////////

module display_asserts (
    input logic        clk_74a,
    input logic        reset_n,
    input logic [23:0] video_rgb,
    input logic        video_de,
    input logic        video_vs
);

    // vsync is a single clock wide
    vs_one_cycle: assert property (@(posedge clk_74a) disable iff (!reset_n)
        video_vs |=> !video_vs)
        else $error("video_vs stayed high for more than one clock");

    // no active pixel during vsync
    de_not_in_vs: assert property (@(posedge clk_74a) disable iff (!reset_n)
        !(video_de && video_vs))
        else $error("video_de and video_vs high on the same clock");

    // blanking must be black
    rgb_black_in_blank: assert property (@(posedge clk_74a) disable iff (!reset_n)
        !video_de |-> (video_rgb == 24'd0))
        else $error("video_rgb not black while video_de is low");

endmodule

bind display_core display_asserts i_display_asserts (
    .clk_74a   (clk_74a),
    .reset_n   (reset_n),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_vs  (video_vs)
);

// File: display_core.sv
////////////////////////////////////////////////////////////
// top level of the framebuffer display core
// host writes pixels over the bridge, video scans them out
////////////////////////////////////////////////////////////

module display_core import display_pkg::*; #(
    parameter int h_bporch = 10,
    parameter int h_active = 320,
    parameter int h_total  = 400,
    parameter int v_bporch = 10,
    parameter int v_active = 288,
    parameter int v_total  = 512,
    parameter int fb_words = 46080
) (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  logic [31:0] bridge_addr,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_vs,
    output logic        video_hs
);

    fb_wr_t      fb_wr;
    fb_word_u    fb_rd_data;
    logic [23:0] fb_rd_addr;
    lb_wr_t      lb_wr;
    rgb565_t     lb_q;
    logic [15:0] lb_rd_addr;
    vid_strobe_t strobe;
    logic        new_frame;
    logic        next_line;
    logic        line_sel;
    logic        border;
    logic        display_enable;

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////

    bridge_regs i_bridge_regs (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .fb_wr          (fb_wr),
        .border         (border),
        .display_enable (display_enable)
    );

    frame_ram #(.fb_words(fb_words)) i_frame_ram (
        .clk_74a (clk_74a),
        .fb_wr   (fb_wr),
        .rd_addr (fb_rd_addr),
        .rd_data (fb_rd_data)
    );

    ////////////////////////////////////////////////////////////
    // video side
    ////////////////////////////////////////////////////////////

    video_timing #(
        .h_bporch (h_bporch),
        .h_active (h_active),
        .h_total  (h_total),
        .v_bporch (v_bporch),
        .v_active (v_active),
        .v_total  (v_total)
    ) i_video_timing (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .strobe    (strobe),
        .new_frame (new_frame),
        .next_line (next_line),
        .line_sel  (line_sel),
        .rd_addr   (lb_rd_addr)
    );

    line_fetch_fsm #(.h_active(h_active)) i_line_fetch_fsm (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .new_frame      (new_frame),
        .next_line      (next_line),
        .display_enable (display_enable),
        .fb_rd_addr     (fb_rd_addr),
        .fb_rd_data     (fb_rd_data),
        .lb_wr          (lb_wr)
    );

    line_buffer #(.h_active(h_active)) i_line_buffer (
        .clk_74a  (clk_74a),
        .wr       (lb_wr),
        .line_sel (line_sel),
        .rd_addr  (lb_rd_addr),
        .q        (lb_q)
    );

    pixel_out #(
        .h_active (h_active),
        .v_active (v_active)
    ) i_pixel_out (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .strobe    (strobe),
        .q         (lb_q),
        .border    (border),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_vs  (video_vs),
        .video_hs  (video_hs)
    );

endmodule

// File: display_pkg.sv
////////////////////////////////////////////////////////////
// shared types for the framebuffer display core
// pixel formats, the frame memory word, timing strobes and
// the bridge register map, pulled in by wildcard import
////////////////////////////////////////////////////////////

package display_pkg;

    // one stored pixel
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one pixel as sent to the scaler
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    // frame memory word, bridge data or two pixels
    // low half holds the even pixel
    typedef union packed {
        logic [31:0]        raw;
        rgb565_t [1:0]      pix;
    } fb_word_u;

    // timing state handed to the pixel stage
    typedef struct packed {
        logic        de;
        logic        vs;
        logic        hs;
        logic [15:0] vis_x;
        logic [15:0] vis_y;
    } vid_strobe_t;

    // single frame memory write
    typedef struct packed {
        logic        wr;
        logic [23:0] addr;
        fb_word_u    data;
    } fb_wr_t;

    // single line buffer write
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        rgb565_t     data;
    } lb_wr_t;

    // bridge register map
    localparam logic [31:0] addr_border = 32'h5000_0000;
    localparam logic [31:0] addr_enable = 32'h5100_0000;

    // debug border colors
    localparam logic [23:0] color_left   = 24'hff_ffff;
    localparam logic [23:0] color_right  = 24'h00_ff00;
    localparam logic [23:0] color_top    = 24'hff_0000;
    localparam logic [23:0] color_bottom = 24'h00_00ff;

endpackage

// File: frame_ram.sv
////////////////////////////////////////////////////////////
// on-chip frame memory of 32-bit words
// bridge writes on one port, line fetch reads on the other
// with one clock of read latency
////////////////////////////////////////////////////////////

module frame_ram import display_pkg::*; #(
    parameter int fb_words = 46080
) (
    input  logic        clk_74a,
    input  fb_wr_t      fb_wr,
    input  logic [23:0] rd_addr,
    output fb_word_u    rd_data
);

    // index width for the word array
    localparam int aw = $clog2(fb_words);

    fb_word_u mem [0:fb_words-1];

    // write port
    always_ff @(posedge clk_74a) begin
        if (fb_wr.wr) begin
            mem[fb_wr.addr[aw-1:0]] <= fb_wr.data;
        end
    end

    // registered read port
    always_ff @(posedge clk_74a) begin
        rd_data <= mem[rd_addr[aw-1:0]];
    end

endmodule

// File: line_buffer.sv
////////////////////////////////////////////////////////////
// ping-pong scanline store, two banks of one line each
// fetch fills the bank named by line_sel while video
// reads the other one with a registered read
////////////////////////////////////////////////////////////

module line_buffer import display_pkg::*; #(
    parameter int h_active = 320
) (
    input  logic        clk_74a,
    input  lb_wr_t      wr,
    input  logic        line_sel,
    input  logic [15:0] rd_addr,
    output rgb565_t     q
);

    // bank bit sits above the pixel index
    localparam int lw = $clog2(h_active);

    rgb565_t     mem [0:(2 << lw) - 1];
    logic        rd_bank;
    logic [lw:0] wr_idx;
    logic [lw:0] rd_idx;

    assign wr_idx = {line_sel, wr.addr[lw-1:0]};
    assign rd_idx = {rd_bank, rd_addr[lw-1:0]};

    always_ff @(posedge clk_74a) begin
        if (wr.wr) begin
            mem[wr_idx] <= wr.data;
        end
        q <= mem[rd_idx];
        // switch read bank after the last pixel of a line
        // so the toggle at hsync never splits a displayed line
        if (rd_addr == 16'(h_active - 1)) begin
            rd_bank <= line_sel;
        end
    end

endmodule

// File: line_fetch_fsm.sv
////////////////////////////////////////////////////////////
// copies one scanline from frame memory into the line buffer
// started by next_line, two pixels per memory word, black
// pixels instead of memory data while scanout is disabled
////////////////////////////////////////////////////////////

module line_fetch_fsm import display_pkg::*; #(
    parameter int h_active = 320
) (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  logic        new_frame,
    input  logic        next_line,
    input  logic        display_enable,
    output logic [23:0] fb_rd_addr,
    input  fb_word_u    fb_rd_data,
    output lb_wr_t      lb_wr
);

    localparam int          words_per_line = h_active / 2;
    localparam logic [1:0]  st_idle        = 2'd0;
    localparam logic [1:0]  st_fetch       = 2'd1;
    localparam logic [1:0]  st_drain       = 2'd2;

    logic [1:0]  state;
    logic [15:0] line_cnt;
    logic [15:0] pix_cnt;
    logic [15:0] slot_pix;
    logic        slot_valid;

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            state      <= st_idle;
            line_cnt   <= 16'd0;
            pix_cnt    <= 16'd0;
            fb_rd_addr <= 24'd0;
            slot_pix   <= 16'd0;
            slot_valid <= 1'b0;
        end else begin
            // read data lands one clock after its address
            slot_valid <= (state == st_fetch);
            slot_pix   <= pix_cnt;
            case (state)
                st_idle: begin
                    if (new_frame) begin
                        line_cnt <= 16'd0;
                    end else if (next_line) begin
                        // scanline base in words
                        fb_rd_addr <= 24'(line_cnt) * 24'(words_per_line);
                        line_cnt   <= line_cnt + 16'd1;
                        pix_cnt    <= 16'd0;
                        state      <= st_fetch;
                    end
                end
                st_fetch: begin
                    pix_cnt <= pix_cnt + 16'd1;
                    // next word after the odd pixel
                    if (pix_cnt[0]) begin
                        fb_rd_addr <= fb_rd_addr + 24'd1;
                    end
                    if (pix_cnt == 16'(h_active - 1)) begin
                        state <= st_drain;
                    end
                end
                // last pixel still in flight
                default: state <= st_idle;
            endcase
        end
    end

    // even pixel in the low half of the word
    always_comb begin
        lb_wr.wr   = slot_valid;
        lb_wr.addr = slot_pix;
        lb_wr.data = display_enable ? fb_rd_data.pix[slot_pix[0]] : rgb565_t'(16'd0);
    end

endmodule

// File: pixel_out.sv
////////////////////////////////////////////////////////////
// final pixel stage, rgb565 to rgb888 expansion with the
// optional debug border, registered sync and data enable
////////////////////////////////////////////////////////////

module pixel_out import display_pkg::*; #(
    parameter int h_active = 320,
    parameter int v_active = 288
) (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  vid_strobe_t strobe,
    input  rgb565_t     q,
    input  logic        border,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_vs,
    output logic        video_hs
);

    rgb888_t expanded;
    rgb888_t shown;

    always_comb begin
        // replicate top bits into the new low bits
        expanded.red   = {q.red, q.red[4:2]};
        expanded.green = {q.green, q.green[5:4]};
        expanded.blue  = {q.blue, q.blue[4:2]};
        shown = expanded;
        // left, right, top, bottom in that order
        if (border) begin
            if (strobe.vis_x == 16'd0) begin
                shown = color_left;
            end else if (strobe.vis_x == 16'(h_active - 1)) begin
                shown = color_right;
            end else if (strobe.vis_y == 16'd0) begin
                shown = color_top;
            end else if (strobe.vis_y == 16'(v_active - 1)) begin
                shown = color_bottom;
            end
        end
    end

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= 24'd0;
            video_de  <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
        end else begin
            // blanking is always black
            video_rgb <= strobe.de ? shown : 24'd0;
            video_de  <= strobe.de;
            video_vs  <= strobe.vs;
            video_hs  <= strobe.hs;
        end
    end

endmodule

// File: tb_clock.sv
////////////////////////////////////////////////////////////
// testbench clock and reset source
// free running clock, reset_n held low for the first cycles
////////////////////////////////////////////////////////////

module tb_clock #(
    parameter int period       = 20,
    parameter int reset_cycles = 4
) (
    output logic clk_74a,
    output logic reset_n
);

    initial begin
        clk_74a = 1'b0;
        forever #(period / 2) clk_74a = ~clk_74a;
    end

    // release on a falling edge, away from the DUT's active edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(negedge clk_74a);
        reset_n = 1'b1;
    end

endmodule

// File: tb_display_core.sv
////////////////////////////////////////////////////////////
// directed testbench for the framebuffer display core
// loads a random frame over the bridge, then checks whole
// frames of video against a pixel model of the frame memory
////////////////////////////////////////////////////////////

module tb_display_core import display_pkg::*; ();

    // small video mode
    localparam int h_bporch = 2;
    localparam int h_active = 16;
    localparam int h_total  = 40;
    localparam int v_bporch = 2;
    localparam int v_active = 8;
    localparam int v_total  = 16;
    localparam int fb_words = 64;

    localparam int frame_cycles   = h_total * v_total;
    localparam int frame_pixels   = h_active * v_active;
    localparam int num_tests      = 5;
    // six frames per test
    localparam int timeout_cycles = num_tests * 6 * frame_cycles;

    logic        clk_74a;
    logic        reset_n;
    logic [31:0] bridge_addr;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic        bridge_rd;
    logic [31:0] bridge_rd_data;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;

    logic [31:0] rng_state;
    logic [15:0] pix_model [0:frame_pixels-1];
    string       test_name;
    int          cycle_cnt = 0;

    tb_clock #(.period(20), .reset_cycles(4)) i_clock (
        .clk_74a (clk_74a),
        .reset_n (reset_n)
    );

    display_core #(
        .h_bporch (h_bporch),
        .h_active (h_active),
        .h_total  (h_total),
        .v_bporch (v_bporch),
        .v_active (v_active),
        .v_total  (v_total),
        .fb_words (fb_words)
    ) i_dut (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // 5/6/5 fields widened by repeating their top bits
    function automatic logic [23:0] expand_565(input logic [15:0] p);
        return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
    endfunction

    // expected output color at visible x, y
    function automatic logic [23:0] expected_pixel(input int x, input int y,
                                                   input logic border_on,
                                                   input logic enable_on);
        logic [15:0] p;
        logic [23:0] rgb;
        p   = enable_on ? pix_model[y * h_active + x] : 16'd0;
        rgb = expand_565(p);
        // left, right, top, bottom priority
        if (border_on) begin
            if (x == 0) begin
                rgb = color_left;
            end else if (x == h_active - 1) begin
                rgb = color_right;
            end else if (y == 0) begin
                rgb = color_top;
            end else if (y == v_active - 1) begin
                rgb = color_bottom;
            end
        end
        return rgb;
    endfunction

    ////////////////////////////////////////////////////////////
    // error reporting and bus helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
        $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
        stop_run();
    endtask

    // one bridge write, held for a single clock
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    // read data is combinational from the address
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk_74a);
        data        = bridge_rd_data;
        bridge_rd   = 1'b0;
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        bus_read(addr, data);
        assert (data == expected) else report_mismatch(expected, data);
    endtask

    // returns on the falling edge where vsync is seen
    task automatic wait_vs();
        @(negedge clk_74a);
        while (!video_vs) @(negedge clk_74a);
    endtask

    // one full frame from vsync, de pixels checked by raster index
    task automatic capture_frame(input logic border_on, input logic enable_on);
        int de_cnt;
        logic [23:0] exp_rgb;
        de_cnt = 0;
        wait_vs();
        for (int i = 0; i < frame_cycles; i++) begin
            if (i != 0) @(negedge clk_74a);
            if (video_de) begin
                exp_rgb = expected_pixel(de_cnt % h_active, de_cnt / h_active,
                                         border_on, enable_on);
                assert (video_rgb == exp_rgb)
                    else report_mismatch(32'(exp_rgb), 32'(video_rgb));
                de_cnt = de_cnt + 1;
            end
        end
        assert (de_cnt == frame_pixels)
            else report_mismatch(32'(frame_pixels), 32'(de_cnt));
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_register_readback();
        test_name = "register_readback";
        // border comes up on
        check_read(addr_border, 32'd1);
        bus_write(addr_border, 32'd0);
        check_read(addr_border, 32'd0);
        // enable is write only, even once set
        bus_write(addr_enable, 32'd1);
        check_read(addr_enable, 32'd0);
        check_read(32'h0000_0010, 32'd0);
        check_read(32'h1234_5678, 32'd0);
    endtask

    task automatic test_frame_content();
        test_name = "frame_content";
        for (int w = 0; w < fb_words; w++) begin
            rng_state = next_random(rng_state);
            // even pixel in the low half
            pix_model[2 * w]     = rng_state[15:0];
            pix_model[2 * w + 1] = rng_state[31:16];
            bus_write(32'(w * 4), rng_state);
        end
        bus_write(addr_border, 32'd0);
        bus_write(addr_enable, 32'd1);
        wait_vs();
        capture_frame(1'b0, 1'b1);
    endtask

    task automatic test_border_overlay();
        test_name = "border_overlay";
        bus_write(addr_border, 32'd1);
        wait_vs();
        capture_frame(1'b1, 1'b1);
    endtask

    task automatic test_display_disable();
        test_name = "display_disable";
        bus_write(addr_border, 32'd0);
        bus_write(addr_enable, 32'd0);
        wait_vs();
        capture_frame(1'b0, 1'b0);
    endtask

    task automatic test_sync_structure();
        int de_cnt;
        int hs_cnt;
        int vs_cnt;
        test_name = "sync_structure";
        de_cnt = 0;
        hs_cnt = 0;
        vs_cnt = 0;
        wait_vs();
        for (int i = 0; i < frame_cycles; i++) begin
            if (i != 0) @(negedge clk_74a);
            if (video_de) de_cnt = de_cnt + 1;
            if (video_hs) hs_cnt = hs_cnt + 1;
            if (video_vs) vs_cnt = vs_cnt + 1;
        end
        assert (de_cnt == frame_pixels) else report_mismatch(32'(frame_pixels), 32'(de_cnt));
        assert (hs_cnt == v_total) else report_mismatch(32'(v_total), 32'(hs_cnt));
        assert (vs_cnt == 1) else report_mismatch(32'd1, 32'(vs_cnt));
    endtask

    // run limit
    always @(posedge clk_74a) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout, tests did not finish within %0d clock cycles", timeout_cycles);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        bridge_addr    = 32'd0;
        bridge_wr      = 1'b0;
        bridge_wr_data = 32'd0;
        bridge_rd      = 1'b0;
        rng_state      = 32'h8d8f_0198;
        test_name      = "reset";
        @(posedge reset_n);
        repeat (2) @(negedge clk_74a);
        test_register_readback();
        test_frame_content();
        test_border_overlay();
        test_display_disable();
        test_sync_structure();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: verilog.f
display_pkg.sv
bridge_regs.sv
frame_ram.sv
line_buffer.sv
video_timing.sv
line_fetch_fsm.sv
pixel_out.sv
display_core.sv
tb_clock.sv
display_asserts.sv
tb_display_core.sv

// File: video_timing.sv
////////////////////////////////////////////////////////////
// raster counters for the display core
// makes sync and data enable strobes, the per-line fetch
// pulse with its bank toggle, and line buffer addressing
////////////////////////////////////////////////////////////

module video_timing import display_pkg::*; #(
    parameter int h_bporch = 10,
    parameter int h_active = 320,
    parameter int h_total  = 400,
    parameter int v_bporch = 10,
    parameter int v_active = 288,
    parameter int v_total  = 512
) (
    input  logic        clk_74a,
    input  logic        reset_n,
    output vid_strobe_t strobe,
    output logic        new_frame,
    output logic        next_line,
    output logic        line_sel,
    output logic [15:0] rd_addr
);

    // hsync a few clocks after vsync, not on the same cycle
    localparam logic [15:0] hs_x = 16'd3;

    logic [15:0] x_cnt;
    logic [15:0] y_cnt;
    logic        h_act;
    logic        v_act;
    logic        fetch_row;

    assign h_act = (x_cnt >= 16'(h_bporch)) && (x_cnt < 16'(h_bporch + h_active));
    assign v_act = (y_cnt >= 16'(v_bporch)) && (y_cnt < 16'(v_bporch + v_active));

    // fetch runs one line ahead of each visible line
    assign fetch_row = (y_cnt >= 16'(v_bporch - 1)) &&
                       (y_cnt <= 16'(v_bporch + v_active - 2));

    // decoded from the counters, registered in the pixel stage
    always_comb begin
        strobe.de    = h_act && v_act;
        strobe.vs    = (x_cnt == 16'd0) && (y_cnt == 16'd0);
        strobe.hs    = (x_cnt == hs_x);
        strobe.vis_x = x_cnt - 16'(h_bporch);
        strobe.vis_y = y_cnt - 16'(v_bporch);
    end

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt     <= 16'd0;
            y_cnt     <= 16'd0;
            new_frame <= 1'b0;
            next_line <= 1'b0;
            line_sel  <= 1'b0;
            rd_addr   <= 16'd0;
        end else begin
            // x wraps at h_total, y steps on the wrap
            if (x_cnt == 16'(h_total - 1)) begin
                x_cnt <= 16'd0;
                y_cnt <= (y_cnt == 16'(v_total - 1)) ? 16'd0 : y_cnt + 16'd1;
            end else begin
                x_cnt <= x_cnt + 16'd1;
            end

            new_frame <= (x_cnt == 16'd0) && (y_cnt == 16'd0);

            // fetch pulse lines up with hsync
            next_line <= 1'b0;
            if ((x_cnt == hs_x) && fetch_row) begin
                next_line <= 1'b1;
                line_sel  <= ~line_sel;
            end

            // one clock early for the registered line buffer read
            if (x_cnt >= 16'(h_bporch - 1)) begin
                rd_addr <= rd_addr + 16'd1;
            end else begin
                rd_addr <= 16'd0;
            end
        end
    end

endmodule
